//--- tb.f
verilog/dbg_pkg.sv
verilog/dm_ram.sv
verilog/dm_mem_arbiter.sv
verilog/dbg_mem_access.sv
verilog/dbg_sys_ctrl.sv
verilog/dbg_host_if.sv
verilog/dbg_tile_top.sv
verif/dm_mem_arbiter_chk.sv
verif/tb_dbg_tile.sv

//--- verif/dm_mem_arbiter_chk.sv
// Memory arbiter checker
`timescale 1ns/1ps

module dm_mem_arbiter_chk (
   input logic clk_i,
   input logic rst_n_i,
   input logic cpu_hold_i,
   input logic dbg_ready_i,
   input logic dbg_we_i,
   input logic dbg_rvalid_i,
   input logic cpu_ready_i,
   input logic cpu_we_i,
   input logic cpu_rvalid_i
);

   // One grant per cycle at most
   a_single_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(dbg_ready_i && cpu_ready_i))
      else $error("Both requesters granted in the same cycle");

   a_cpu_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(cpu_hold_i && cpu_ready_i))
      else $error("CPU granted while held in reset");

   // Read data returns to the owner one cycle later
   a_dbg_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dbg_ready_i && !dbg_we_i) |=> (dbg_rvalid_i && !cpu_rvalid_i))
      else $error("Debug read not followed by its rvalid");

   a_cpu_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (cpu_ready_i && !cpu_we_i) |=> (cpu_rvalid_i && !dbg_rvalid_i))
      else $error("CPU read not followed by its rvalid");

   a_dbg_rvalid_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dbg_rvalid_i |-> $past(dbg_ready_i && !dbg_we_i))
      else $error("Debug rvalid without a granted read");

   a_cpu_rvalid_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cpu_rvalid_i |-> $past(cpu_ready_i && !cpu_we_i))
      else $error("CPU rvalid without a granted read");

endmodule

bind dm_mem_arbiter dm_mem_arbiter_chk u_chk (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .cpu_hold_i   (cpu_hold_i),
   .dbg_ready_i  (dbg_ready_o),
   .dbg_we_i     (dbg_we_i),
   .dbg_rvalid_i (dbg_rvalid_o),
   .cpu_ready_i  (cpu_ready_o),
   .cpu_we_i     (cpu_we_i),
   .cpu_rvalid_i (cpu_rvalid_o)
);

//--- verif/tb_dbg_tile.sv
// Debug tile testbench
`timescale 1ns/1ps

module tb_dbg_tile import dbg_pkg::*; ();

   localparam dbg_word_t SYS_ID   = 16'hA5C3;
   localparam int N_RAND          = 200;
   localparam int N_MIXED         = 60;
   localparam int N_CROSS         = 32;
   localparam int TOTAL_OPS       = N_RAND + N_MIXED + 2 * N_CROSS + 40;
   localparam int TIMEOUT_CYCLES  = TOTAL_OPS * 40 + 10;

   logic      clk_i;
   logic      rst_n_i;
   logic      host_in_valid_i;
   dbg_word_t host_in_data_i;
   logic      host_in_ready_o;
   logic      host_out_valid_o;
   dbg_word_t host_out_data_o;
   logic      host_out_ready_i;
   logic      cpu_req_valid_i;
   logic      cpu_req_we_i;
   mem_addr_t cpu_req_addr_i;
   dbg_word_t cpu_req_wdata_i;
   logic      cpu_req_ready_o;
   logic      cpu_rvalid_o;
   dbg_word_t cpu_rdata_o;
   logic      cpu_rst_o;

   // Reference model of the tile state
   dbg_word_t model_mem [256];
   logic      model_known [256];
   dbg_word_t model_scratch;
   logic      model_ctrl;

   int   errors;
   int   checks;
   logic bp_en;
   logic host_done;

   dbg_tile_top #(.SYSTEM_ID(SYS_ID)) u_dut (.*);

   always #2 clk_i = ~clk_i;

   task automatic report_mismatch(input string name, input dbg_word_t exp, input dbg_word_t act);
      $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
      errors++;
   endtask

   task automatic report_fail(input string what);
      $display("[ERROR] %0t ns %s", $time, what);
      errors++;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   function automatic dbg_word_t make_hdr(input dbg_dest_t dest, input logic we,
                                          input mem_addr_t addr);
      dbg_word_t hdr;
      hdr = '0;
      hdr[15:14] = dest;
      hdr[HDR_WRITE_BIT] = we;
      // Ignored bits carry noise
      hdr[11:8] = 4'($urandom);
      hdr[7:0] = addr;
      return hdr;
   endfunction

   // All tasks start and end 1 ns after a rising edge
   task automatic host_send(input dbg_word_t word);
      host_in_valid_i = 1'b1;
      host_in_data_i  = word;
      @(negedge clk_i);
      while (!host_in_ready_o)
         @(negedge clk_i);
      @(posedge clk_i);
      #1;
      host_in_valid_i = 1'b0;
   endtask

   task automatic host_recv(output dbg_word_t word);
      logic      held;
      logic      done;
      dbg_word_t held_word;
      held = 1'b0;
      done = 1'b0;
      held_word = '0;
      while (!done) begin
         host_out_ready_i = bp_en ? ($urandom % 2 == 0) : 1'b1;
         @(negedge clk_i);
         if (host_in_ready_o)
            report_fail("host_in_ready_o high while a response was pending");
         if (held && (!host_out_valid_o || host_out_data_o !== held_word))
            report_fail("host response changed while host_out_ready_i was low");
         held = host_out_valid_o && !host_out_ready_i;
         held_word = host_out_data_o;
         if (host_out_valid_o && host_out_ready_i) begin
            word = host_out_data_o;
            done = 1'b1;
         end
         @(posedge clk_i);
         #1;
      end
      host_out_ready_i = 1'b0;
   endtask

   task automatic host_check(input dbg_word_t hdr, input dbg_word_t wdata, input dbg_word_t exp);
      dbg_word_t resp;
      host_send(hdr);
      if (hdr[HDR_WRITE_BIT])
         host_send(wdata);
      host_recv(resp);
      if (resp !== exp)
         report_mismatch("host_out_data_o", exp, resp);
      checks++;
   endtask

   task automatic scm_write(input mem_addr_t addr, input dbg_word_t data);
      dbg_word_t hdr;
      hdr = make_hdr(DEST_SCM, 1'b1, addr);
      host_check(hdr, data, hdr);
      if (addr == SCM_REG_SCRATCH)
         model_scratch = data;
      else if (addr == SCM_REG_CTRL)
         model_ctrl = data[0];
   endtask

   task automatic scm_read(input mem_addr_t addr);
      dbg_word_t exp;
      exp = '0;
      if (addr == SCM_REG_ID)
         exp = SYS_ID;
      else if (addr == SCM_REG_SCRATCH)
         exp = model_scratch;
      else if (addr == SCM_REG_CTRL)
         exp[0] = model_ctrl;
      host_check(make_hdr(DEST_SCM, 1'b0, addr), '0, exp);
   endtask

   task automatic mam_write(input mem_addr_t addr, input dbg_word_t data);
      dbg_word_t hdr;
      hdr = make_hdr(DEST_MAM, 1'b1, addr);
      host_check(hdr, data, hdr);
      model_mem[addr] = data;
      model_known[addr] = 1'b1;
   endtask

   task automatic mam_read(input mem_addr_t addr);
      host_check(make_hdr(DEST_MAM, 1'b0, addr), '0, model_mem[addr]);
   endtask

   task automatic random_debug_op(input mem_addr_t addr);
      if ($urandom % 2 == 0 || !model_known[addr])
         mam_write(addr, dbg_word_t'($urandom));
      else
         mam_read(addr);
   endtask

   task automatic cpu_access(input logic we, input mem_addr_t addr, input dbg_word_t wdata);
      cpu_req_valid_i = 1'b1;
      cpu_req_we_i    = we;
      cpu_req_addr_i  = addr;
      cpu_req_wdata_i = wdata;
      @(negedge clk_i);
      while (!cpu_req_ready_o)
         @(negedge clk_i);
      @(posedge clk_i);
      #1;
      cpu_req_valid_i = 1'b0;
      if (we) begin
         model_mem[addr] = wdata;
         model_known[addr] = 1'b1;
      end else begin
         // Read data follows acceptance by one cycle
         @(negedge clk_i);
         if (!cpu_rvalid_o)
            report_fail("cpu_rvalid_o missing one cycle after the read was accepted");
         else if (cpu_rdata_o !== model_mem[addr])
            report_mismatch("cpu_rdata_o", model_mem[addr], cpu_rdata_o);
         checks++;
         @(posedge clk_i);
         #1;
      end
   endtask

   // CPU side keeps to the upper half of memory
   task automatic cpu_traffic();
      mem_addr_t addr;
      while (!host_done) begin
         addr = mem_addr_t'(128 + $urandom % 128);
         if ($urandom % 2 == 0 || !model_known[addr])
            cpu_access(1'b1, addr, dbg_word_t'($urandom));
         else
            cpu_access(1'b0, addr, '0);
         idle_cycles($urandom % 3);
      end
   endtask

   initial begin
      dbg_word_t   hdr;
      dbg_word_t   exp;
      mem_addr_t   addr;
      void'($urandom(87));
      clk_i = 1'b0;
      rst_n_i = 1'b0;
      host_in_valid_i = 1'b0;
      host_in_data_i = '0;
      host_out_ready_i = 1'b0;
      cpu_req_valid_i = 1'b0;
      cpu_req_we_i = 1'b0;
      cpu_req_addr_i = '0;
      cpu_req_wdata_i = '0;
      errors = 0;
      checks = 0;
      bp_en = 1'b0;
      host_done = 1'b0;
      model_scratch = '0;
      model_ctrl = 1'b1;
      for (int i = 0; i < 256; i++)
         model_known[i] = 1'b0;
      repeat (10) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;

      // State out of reset
      if (host_out_valid_o !== 1'b0)
         report_fail("host_out_valid_o not low after reset");
      if (cpu_rvalid_o !== 1'b0)
         report_fail("cpu_rvalid_o not low after reset");
      if (cpu_rst_o !== 1'b1)
         report_fail("cpu_rst_o not high after reset");
      scm_read(SCM_REG_ID);
      scm_read(SCM_REG_CTRL);

      // System control registers
      scm_write(SCM_REG_SCRATCH, dbg_word_t'($urandom));
      scm_read(SCM_REG_SCRATCH);
      scm_write(SCM_REG_ID, 16'hFFFF);
      scm_read(SCM_REG_ID);
      scm_read(8'h07);

      // CPU held until the control register releases it
      fork
         cpu_access(1'b1, 8'd200, 16'hC0DE);
         begin
            repeat (20) begin
               @(negedge clk_i);
               if (cpu_req_ready_o)
                  report_fail("cpu_req_ready_o rose while the CPU was held in reset");
            end
            @(posedge clk_i);
            #1;
            scm_write(SCM_REG_CTRL, 16'h0000);
         end
      join
      if (cpu_rst_o !== 1'b0)
         report_fail("cpu_rst_o still high after the control register was cleared");
      cpu_access(1'b0, 8'd200, '0);
      scm_read(SCM_REG_CTRL);

      // Concurrent debug and CPU traffic with host back-pressure
      bp_en = 1'b1;
      fork
         begin
            for (int i = 0; i < N_RAND; i++)
               random_debug_op(mem_addr_t'($urandom % 128));
            host_done = 1'b1;
         end
         cpu_traffic();
      join
      for (int i = 0; i < N_CROSS; i++) begin
         addr = mem_addr_t'(128 + i * 4);
         if (model_known[addr])
            mam_read(addr);
         addr = mem_addr_t'(i * 4);
         if (model_known[addr])
            cpu_access(1'b0, addr, '0);
      end

      // Unknown destinations answer with the error bit and touch nothing
      mam_write(8'h05, dbg_word_t'($urandom));
      for (int d = 2; d < 4; d++) begin
         for (int w = 0; w < 2; w++) begin
            hdr = make_hdr(dbg_dest_t'(d), w[0], 8'h05);
            exp = hdr;
            exp[HDR_ERR_BIT] = 1'b1;
            host_check(hdr, ~model_mem[5], exp);
         end
      end
      mam_read(8'h05);

      // Mixed register and memory traffic
      for (int i = 0; i < N_MIXED; i++) begin
         case ($urandom % 4)
            0: scm_write(SCM_REG_SCRATCH, dbg_word_t'($urandom));
            1: scm_read(mem_addr_t'($urandom % 4));
            default: random_debug_op(mem_addr_t'($urandom));
         endcase
      end

      $display("Run finished with %0d checks and %0d errors", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk_i);
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

//--- verilog/dbg_host_if.sv
// Host request decoder
`timescale 1ns/1ps

module dbg_host_if import dbg_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      host_in_valid_i,
   input  dbg_word_t host_in_data_i,
   output logic      host_in_ready_o,
   output logic      host_out_valid_o,
   output dbg_word_t host_out_data_o,
   input  logic      host_out_ready_i,
   output logic      scm_req_valid_o,
   output logic      scm_req_we_o,
   output mem_addr_t scm_req_addr_o,
   output dbg_word_t scm_req_wdata_o,
   input  logic      scm_req_ready_i,
   input  logic      scm_resp_valid_i,
   input  dbg_word_t scm_resp_data_i,
   output logic      mam_req_valid_o,
   output logic      mam_req_we_o,
   output mem_addr_t mam_req_addr_o,
   output dbg_word_t mam_req_wdata_o,
   input  logic      mam_req_ready_i,
   input  logic      mam_resp_valid_i,
   input  dbg_word_t mam_resp_data_i
);

   typedef enum logic [2:0] {ST_IDLE, ST_DATA, ST_ISSUE, ST_WAIT, ST_RESP} state_t;

   state_t    state_q;
   state_t    state_d;
   dbg_word_t hdr_q;
   dbg_word_t wdata_q;
   dbg_word_t resp_q;
   dbg_word_t err_word;
   dbg_dest_t in_dest;
   dbg_dest_t hdr_dest;
   logic      in_write;
   logic      sel_req_ready;
   logic      sel_resp_valid;
   dbg_word_t sel_resp_data;
   logic      hdr_load;
   logic      data_load;
   logic      err_load;
   logic      resp_hit;

   assign in_dest  = host_in_data_i[HDR_DEST_LSB +: 2];
   assign in_write = host_in_data_i[HDR_WRITE_BIT];
   assign hdr_dest = hdr_q[HDR_DEST_LSB +: 2];

   // Responder seen from the latched header
   assign sel_req_ready  = (hdr_dest == DEST_SCM) ? scm_req_ready_i : mam_req_ready_i;
   assign sel_resp_valid = (hdr_dest == DEST_SCM) ? scm_resp_valid_i : mam_resp_valid_i;
   assign sel_resp_data  = (hdr_dest == DEST_SCM) ? scm_resp_data_i : mam_resp_data_i;

   assign hdr_load  = (state_q == ST_IDLE) && host_in_valid_i;
   assign data_load = (state_q == ST_DATA) && host_in_valid_i;
   assign err_load  = (hdr_load && !in_write && !dest_known(in_dest)) ||
                      (data_load && !dest_known(hdr_dest));
   assign resp_hit  = ((state_q == ST_ISSUE) || (state_q == ST_WAIT)) && sel_resp_valid;

   always_comb begin
      err_word = (state_q == ST_IDLE) ? host_in_data_i : hdr_q;
      err_word[HDR_ERR_BIT] = 1'b1;
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (host_in_valid_i) begin
               if (in_write)
                  state_d = ST_DATA;
               else if (dest_known(in_dest))
                  state_d = ST_ISSUE;
               else
                  state_d = ST_RESP;
            end
         end
         ST_DATA: begin
            if (host_in_valid_i)
               state_d = dest_known(hdr_dest) ? ST_ISSUE : ST_RESP;
         end
         // Control registers answer in the accepting cycle
         ST_ISSUE: begin
            if (sel_resp_valid)
               state_d = ST_RESP;
            else if (sel_req_ready)
               state_d = ST_WAIT;
         end
         ST_WAIT: if (sel_resp_valid) state_d = ST_RESP;
         ST_RESP: if (host_out_ready_i) state_d = ST_IDLE;
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         state_q <= ST_IDLE;
      else
         state_q <= state_d;
   end

   always_ff @(posedge clk_i) begin
      if (hdr_load)
         hdr_q <= host_in_data_i;
      if (data_load)
         wdata_q <= host_in_data_i;
      // A write is answered with its own header
      if (err_load)
         resp_q <= err_word;
      else if (resp_hit)
         resp_q <= hdr_q[HDR_WRITE_BIT] ? hdr_q : sel_resp_data;
   end

   assign host_in_ready_o  = (state_q == ST_IDLE) || (state_q == ST_DATA);
   assign host_out_valid_o = (state_q == ST_RESP);
   assign host_out_data_o  = resp_q;

   assign scm_req_valid_o = (state_q == ST_ISSUE) && (hdr_dest == DEST_SCM);
   assign scm_req_we_o    = hdr_q[HDR_WRITE_BIT];
   assign scm_req_addr_o  = hdr_q[HDR_ADDR_LSB +: 8];
   assign scm_req_wdata_o = wdata_q;

   assign mam_req_valid_o = (state_q == ST_ISSUE) && (hdr_dest == DEST_MAM);
   assign mam_req_we_o    = hdr_q[HDR_WRITE_BIT];
   assign mam_req_addr_o  = hdr_q[HDR_ADDR_LSB +: 8];
   assign mam_req_wdata_o = wdata_q;

endmodule

//--- verilog/dbg_mem_access.sv
// Debug memory access
`timescale 1ns/1ps

module dbg_mem_access import dbg_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      req_valid_i,
   input  logic      req_we_i,
   input  mem_addr_t req_addr_i,
   input  dbg_word_t req_wdata_i,
   output logic      req_ready_o,
   output logic      resp_valid_o,
   output dbg_word_t resp_data_o,
   output logic      mem_valid_o,
   output logic      mem_we_o,
   output mem_addr_t mem_addr_o,
   output dbg_word_t mem_wdata_o,
   input  logic      mem_ready_i,
   input  logic      mem_rvalid_i,
   input  dbg_word_t mem_rdata_i
);

   typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RDWAIT, ST_RESP} state_t;

   state_t    state_q;
   logic      we_q;
   mem_addr_t addr_q;
   dbg_word_t wdata_q;
   dbg_word_t rdata_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE:   if (req_valid_i) state_q <= ST_REQ;
            // Writes finish on acceptance, reads wait for data
            ST_REQ:    if (mem_ready_i) state_q <= we_q ? ST_RESP : ST_RDWAIT;
            ST_RDWAIT: if (mem_rvalid_i) state_q <= ST_RESP;
            ST_RESP:   state_q <= ST_IDLE;
            default:   state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_valid_i && req_ready_o) begin
         we_q    <= req_we_i;
         addr_q  <= req_addr_i;
         wdata_q <= req_wdata_i;
      end
      if ((state_q == ST_RDWAIT) && mem_rvalid_i)
         rdata_q <= mem_rdata_i;
   end

   assign req_ready_o  = (state_q == ST_IDLE);
   assign resp_valid_o = (state_q == ST_RESP);
   assign resp_data_o  = rdata_q;

   assign mem_valid_o = (state_q == ST_REQ);
   assign mem_we_o    = we_q;
   assign mem_addr_o  = addr_q;
   assign mem_wdata_o = wdata_q;

endmodule

//--- verilog/dbg_pkg.sv
// Debug tile shared definitions

package dbg_pkg;

   // Host word, also the register and memory data word
   typedef logic [15:0] dbg_word_t;

   // Memory and register address
   typedef logic [7:0] mem_addr_t;

   // Destination id from the header
   typedef logic [1:0] dbg_dest_t;

   // Destination ids
   localparam dbg_dest_t DEST_SCM = 2'd0;
   localparam dbg_dest_t DEST_MAM = 2'd1;

   // Header layout
   localparam int HDR_DEST_LSB  = 14;
   localparam int HDR_WRITE_BIT = 13;
   localparam int HDR_ERR_BIT   = 12;
   localparam int HDR_ADDR_LSB  = 0;

   // System control register map
   localparam mem_addr_t SCM_REG_ID      = 8'd0;
   localparam mem_addr_t SCM_REG_SCRATCH = 8'd1;
   localparam mem_addr_t SCM_REG_CTRL    = 8'd2;

   // Bit 0 of the control register holds the CPU in reset
   localparam int SCM_CTRL_CPU_RST_BIT = 0;

   // Only two destinations are populated
   function automatic logic dest_known(dbg_dest_t dest);
      return (dest == DEST_SCM) || (dest == DEST_MAM);
   endfunction

endpackage

//--- verilog/dbg_sys_ctrl.sv
// System control registers
`timescale 1ns/1ps

module dbg_sys_ctrl import dbg_pkg::*; #(
   parameter dbg_word_t SYSTEM_ID = 16'h0001
) (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      req_valid_i,
   input  logic      req_we_i,
   input  mem_addr_t req_addr_i,
   input  dbg_word_t req_wdata_i,
   output logic      req_ready_o,
   output logic      resp_valid_o,
   output dbg_word_t resp_data_o,
   output logic      cpu_rst_o
);

   logic      ready_q;
   logic      accept;
   dbg_word_t scratch_q;
   logic      ctrl_q;

   assign accept       = req_valid_i && ready_q;
   assign req_ready_o  = ready_q;
   assign resp_valid_o = accept;
   assign cpu_rst_o    = ctrl_q;

   // Ready follows valid by one cycle, then drops again
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ready_q   <= 1'b0;
         scratch_q <= '0;
         ctrl_q    <= 1'b1;
      end else begin
         ready_q <= req_valid_i && !ready_q;
         if (accept && req_we_i) begin
            case (req_addr_i)
               SCM_REG_SCRATCH: scratch_q <= req_wdata_i;
               SCM_REG_CTRL:    ctrl_q <= req_wdata_i[SCM_CTRL_CPU_RST_BIT];
               default:         ;
            endcase
         end
      end
   end

   always_comb begin
      resp_data_o = '0;
      case (req_addr_i)
         SCM_REG_ID:      resp_data_o = SYSTEM_ID;
         SCM_REG_SCRATCH: resp_data_o = scratch_q;
         SCM_REG_CTRL:    resp_data_o[SCM_CTRL_CPU_RST_BIT] = ctrl_q;
         default:         resp_data_o = '0;
      endcase
   end

endmodule

//--- verilog/dbg_tile_top.sv
// Compute tile debug top level
`timescale 1ns/1ps

module dbg_tile_top import dbg_pkg::*; #(
   parameter dbg_word_t SYSTEM_ID = 16'h0001
) (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      host_in_valid_i,
   input  dbg_word_t host_in_data_i,
   output logic      host_in_ready_o,
   output logic      host_out_valid_o,
   output dbg_word_t host_out_data_o,
   input  logic      host_out_ready_i,
   input  logic      cpu_req_valid_i,
   input  logic      cpu_req_we_i,
   input  mem_addr_t cpu_req_addr_i,
   input  dbg_word_t cpu_req_wdata_i,
   output logic      cpu_req_ready_o,
   output logic      cpu_rvalid_o,
   output dbg_word_t cpu_rdata_o,
   output logic      cpu_rst_o
);

   logic      scm_req_valid, scm_req_we, scm_req_ready, scm_resp_valid;
   mem_addr_t scm_req_addr;
   dbg_word_t scm_req_wdata, scm_resp_data;

   logic      mam_req_valid, mam_req_we, mam_req_ready, mam_resp_valid;
   mem_addr_t mam_req_addr;
   dbg_word_t mam_req_wdata, mam_resp_data;

   logic      mem_valid, mem_we, mem_ready, mem_rvalid;
   mem_addr_t mem_addr;
   dbg_word_t mem_wdata, mem_rdata;

   logic      ram_en, ram_we;
   mem_addr_t ram_addr;
   dbg_word_t ram_wdata, ram_rdata;

   dbg_host_if u_host_if (
      .clk_i, .rst_n_i,
      .host_in_valid_i, .host_in_data_i, .host_in_ready_o,
      .host_out_valid_o, .host_out_data_o, .host_out_ready_i,
      .scm_req_valid_o (scm_req_valid), .scm_req_we_o (scm_req_we),
      .scm_req_addr_o (scm_req_addr), .scm_req_wdata_o (scm_req_wdata),
      .scm_req_ready_i (scm_req_ready), .scm_resp_valid_i (scm_resp_valid),
      .scm_resp_data_i (scm_resp_data),
      .mam_req_valid_o (mam_req_valid), .mam_req_we_o (mam_req_we),
      .mam_req_addr_o (mam_req_addr), .mam_req_wdata_o (mam_req_wdata),
      .mam_req_ready_i (mam_req_ready), .mam_resp_valid_i (mam_resp_valid),
      .mam_resp_data_i (mam_resp_data)
   );

   dbg_sys_ctrl #(.SYSTEM_ID(SYSTEM_ID)) u_sys_ctrl (
      .clk_i, .rst_n_i,
      .req_valid_i (scm_req_valid), .req_we_i (scm_req_we), .req_addr_i (scm_req_addr),
      .req_wdata_i (scm_req_wdata), .req_ready_o (scm_req_ready),
      .resp_valid_o (scm_resp_valid), .resp_data_o (scm_resp_data),
      .cpu_rst_o
   );

   dbg_mem_access u_mem_access (
      .clk_i, .rst_n_i,
      .req_valid_i (mam_req_valid), .req_we_i (mam_req_we), .req_addr_i (mam_req_addr),
      .req_wdata_i (mam_req_wdata), .req_ready_o (mam_req_ready),
      .resp_valid_o (mam_resp_valid), .resp_data_o (mam_resp_data),
      .mem_valid_o (mem_valid), .mem_we_o (mem_we), .mem_addr_o (mem_addr),
      .mem_wdata_o (mem_wdata), .mem_ready_i (mem_ready),
      .mem_rvalid_i (mem_rvalid), .mem_rdata_i (mem_rdata)
   );

   // CPU port is refused while the system control holds it in reset
   dm_mem_arbiter u_arbiter (
      .clk_i, .rst_n_i, .cpu_hold_i (cpu_rst_o),
      .dbg_valid_i (mem_valid), .dbg_we_i (mem_we), .dbg_addr_i (mem_addr),
      .dbg_wdata_i (mem_wdata), .dbg_ready_o (mem_ready),
      .dbg_rvalid_o (mem_rvalid), .dbg_rdata_o (mem_rdata),
      .cpu_valid_i (cpu_req_valid_i), .cpu_we_i (cpu_req_we_i), .cpu_addr_i (cpu_req_addr_i),
      .cpu_wdata_i (cpu_req_wdata_i), .cpu_ready_o (cpu_req_ready_o),
      .cpu_rvalid_o, .cpu_rdata_o,
      .ram_en_o (ram_en), .ram_we_o (ram_we), .ram_addr_o (ram_addr),
      .ram_wdata_o (ram_wdata), .ram_rdata_i (ram_rdata)
   );

   dm_ram u_ram (
      .clk_i, .en_i (ram_en), .we_i (ram_we), .addr_i (ram_addr),
      .wdata_i (ram_wdata), .rdata_o (ram_rdata)
   );

endmodule

//--- verilog/dm_mem_arbiter.sv
// Round-robin data memory arbiter
`timescale 1ns/1ps

module dm_mem_arbiter import dbg_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      cpu_hold_i,
   input  logic      dbg_valid_i,
   input  logic      dbg_we_i,
   input  mem_addr_t dbg_addr_i,
   input  dbg_word_t dbg_wdata_i,
   output logic      dbg_ready_o,
   output logic      dbg_rvalid_o,
   output dbg_word_t dbg_rdata_o,
   input  logic      cpu_valid_i,
   input  logic      cpu_we_i,
   input  mem_addr_t cpu_addr_i,
   input  dbg_word_t cpu_wdata_i,
   output logic      cpu_ready_o,
   output logic      cpu_rvalid_o,
   output dbg_word_t cpu_rdata_o,
   output logic      ram_en_o,
   output logic      ram_we_o,
   output mem_addr_t ram_addr_o,
   output dbg_word_t ram_wdata_o,
   input  dbg_word_t ram_rdata_i
);

   // High when the CPU side wins a tie
   logic prio_cpu_q;
   logic cpu_req;
   logic grant_dbg;
   logic grant_cpu;
   logic rd_dbg_q;
   logic rd_cpu_q;

   // CPU is invisible while held in reset
   assign cpu_req   = cpu_valid_i && !cpu_hold_i;
   assign grant_dbg = dbg_valid_i && (!cpu_req || !prio_cpu_q);
   assign grant_cpu = cpu_req && (!dbg_valid_i || prio_cpu_q);

   assign dbg_ready_o = grant_dbg;
   assign cpu_ready_o = grant_cpu;

   assign ram_en_o    = grant_dbg || grant_cpu;
   assign ram_we_o    = grant_cpu ? cpu_we_i : dbg_we_i;
   assign ram_addr_o  = grant_cpu ? cpu_addr_i : dbg_addr_i;
   assign ram_wdata_o = grant_cpu ? cpu_wdata_i : dbg_wdata_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         prio_cpu_q <= 1'b0;
         rd_dbg_q   <= 1'b0;
         rd_cpu_q   <= 1'b0;
      end else begin
         // Loser of this transfer gets priority next time
         if (ram_en_o)
            prio_cpu_q <= grant_dbg;
         rd_dbg_q <= grant_dbg && !dbg_we_i;
         rd_cpu_q <= grant_cpu && !cpu_we_i;
      end
   end

   // RAM data fans out, rvalid picks the owner
   assign dbg_rvalid_o = rd_dbg_q;
   assign cpu_rvalid_o = rd_cpu_q;
   assign dbg_rdata_o  = ram_rdata_i;
   assign cpu_rdata_o  = ram_rdata_i;

endmodule

//--- verilog/dm_ram.sv
// Tile data RAM
`timescale 1ns/1ps

module dm_ram import dbg_pkg::*; (
   input  logic      clk_i,
   input  logic      en_i,
   input  logic      we_i,
   input  mem_addr_t addr_i,
   input  dbg_word_t wdata_i,
   output dbg_word_t rdata_o
);

   dbg_word_t mem [256];

   // One-cycle read latency
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i)
            mem[addr_i] <= wdata_i;
         else
            rdata_o <= mem[addr_i];
      end
   end

endmodule
